//--- common/game_pkg.sv
package game_pkg;

    // screen coordinate, used for column and row
    typedef logic [9:0] coord_t;

    // step period count
    typedef logic [19:0] speed_t;

    // signed vertical speed
    typedef logic signed [19:0] grav_t;

    typedef enum logic {
        LEVEL_1 = 1'b0,
        LEVEL_2 = 1'b1
    } level_e;

    typedef enum logic [1:0] {
        MOVE_NONE  = 2'd0,
        MOVE_LEFT  = 2'd1,
        MOVE_RIGHT = 2'd2
    } move_e;

    typedef struct packed {
        coord_t snap_y;
        coord_t x_lo;
        coord_t x_hi;
        logic   goal;
    } platform_t;

    localparam int NUM_PLAT_L1 = 9;
    localparam int NUM_PLAT_L2 = 8;

    // entries are snap_y, x_lo, x_hi, goal
    localparam platform_t PLATFORMS_L1 [NUM_PLAT_L1] = '{
        '{10'd373, 10'd0,   10'd150, 1'b0},
        '{10'd373, 10'd190, 10'd350, 1'b0},
        '{10'd373, 10'd415, 10'd475, 1'b0},
        '{10'd373, 10'd540, 10'd600, 1'b0},
        '{10'd283, 10'd540, 10'd600, 1'b0},
        '{10'd233, 10'd415, 10'd500, 1'b0},
        '{10'd158, 10'd305, 10'd375, 1'b0},
        '{10'd122, 10'd210, 10'd250, 1'b0},
        '{10'd240, 10'd160, 10'd200, 1'b1}
    };

    localparam platform_t PLATFORMS_L2 [NUM_PLAT_L2] = '{
        '{10'd373, 10'd0,   10'd75,  1'b0},
        '{10'd373, 10'd140, 10'd200, 1'b0},
        '{10'd263, 10'd20,  10'd75,  1'b0},
        '{10'd153, 10'd0,   10'd45,  1'b0},
        '{10'd43,  10'd20,  10'd150, 1'b0},
        '{10'd213, 10'd165, 10'd250, 1'b0},
        '{10'd423, 10'd340, 10'd600, 1'b0},
        '{10'd213, 10'd470, 10'd500, 1'b0}
    };

    // landing window around each snap row
    localparam coord_t WIN_ABOVE = 10'd2;
    localparam coord_t WIN_BELOW = 10'd7;

    localparam coord_t X_RIGHT_MAX = 10'd629;
    localparam coord_t X_LEFT_MIN  = 10'd3;
    localparam coord_t X_LIMIT     = 10'd630;
    localparam coord_t BOTTOM_Y    = 10'd480;

    localparam grav_t       GRAV_MAX   = 20'sd25;
    localparam grav_t       JUMP_STEP  = 20'sd10;
    localparam grav_t       JUMP_FLOOR = -20'sd20;
    localparam int unsigned GRAV_SHIFT = 3;

    localparam coord_t SPAWN_X      = 10'd5;
    localparam coord_t SPAWN_Y      = 10'd100;
    localparam coord_t RESPAWN_L1_X = 10'd10;
    localparam coord_t RESPAWN_L1_Y = 10'd100;
    localparam coord_t RESPAWN_L2_X = 10'd180;
    localparam coord_t RESPAWN_L2_Y = 10'd250;
    localparam coord_t RESET_X      = 10'd2;
    localparam coord_t RESET_Y      = 10'd100;

endpackage

//--- common/player_state_if.sv
`timescale 1ns/100ps

interface player_state_if;

    // player position, owned by physics
    game_pkg::coord_t x;
    game_pkg::coord_t y;

    // presence and level, owned by level control
    logic             active;
    game_pkg::level_e level;

    // spawn or respawn point, taken by physics on a tick
    logic             spawn_req;
    game_pkg::coord_t spawn_x;
    game_pkg::coord_t spawn_y;

    modport physics (
        output x, y,
        input  active, level, spawn_req, spawn_x, spawn_y
    );

    modport control (
        output active, level, spawn_req, spawn_x, spawn_y,
        input  y
    );

    modport monitor (
        input x, y, active, level, spawn_req, spawn_x, spawn_y
    );

endinterface

//--- common/platform_if.sv
`timescale 1ns/100ps

interface platform_if;

    // request
    game_pkg::level_e level;
    game_pkg::coord_t x;
    game_pkg::coord_t y;

    // result, same cycle
    logic             hit;
    game_pkg::coord_t snap_y;
    logic             goal;

    modport physics (
        output level, x, y,
        input  hit, snap_y, goal
    );

    modport map (
        input  level, x, y,
        output hit, snap_y, goal
    );

endinterface

//--- hdl/step_input.sv
`timescale 1ns/100ps

module step_input (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  game_pkg::speed_t  speed,
    input  logic [2:0]        player_input,
    output logic              tick,
    output game_pkg::move_e   move,
    output logic              jump
);

    game_pkg::speed_t counter;
    logic             right_pressed;
    logic             left_pressed;

    // one step every speed+1 cycles, also recovers if speed drops below the count
    assign tick = start && (counter >= speed);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            counter <= '0;
        end else if (start) begin
            if (tick) begin
                counter <= '0;
            end else begin
                counter <= counter + 20'd1;
            end
        end
    end

    // buttons are active low
    assign right_pressed = !player_input[0];
    assign left_pressed  = !player_input[2];
    assign jump          = !player_input[1];

    always_comb begin
        if (right_pressed && !left_pressed) begin
            move = game_pkg::MOVE_RIGHT;
        end else if (left_pressed && !right_pressed) begin
            move = game_pkg::MOVE_LEFT;
        end else begin
            move = game_pkg::MOVE_NONE;
        end
    end

endmodule

//--- physics/platform_map.sv
`timescale 1ns/100ps

module platform_map (
    platform_if.map plat
);

    function automatic logic in_window(
        input game_pkg::platform_t p,
        input game_pkg::coord_t    x,
        input game_pkg::coord_t    y
    );
        logic in_x;
        logic in_y;
        in_x = (x >= p.x_lo) && (x <= p.x_hi);
        in_y = (y >= p.snap_y - game_pkg::WIN_ABOVE) &&
               (y <= p.snap_y + game_pkg::WIN_BELOW);
        return in_x && in_y;
    endfunction

    // scan from the top index down so the lowest matching entry wins
    always_comb begin
        plat.hit    = 1'b0;
        plat.snap_y = '0;
        plat.goal   = 1'b0;
        if (plat.level == game_pkg::LEVEL_1) begin
            for (int i = game_pkg::NUM_PLAT_L1 - 1; i >= 0; i--) begin
                if (in_window(game_pkg::PLATFORMS_L1[i], plat.x, plat.y)) begin
                    plat.hit    = 1'b1;
                    plat.snap_y = game_pkg::PLATFORMS_L1[i].snap_y;
                    plat.goal   = game_pkg::PLATFORMS_L1[i].goal;
                end
            end
        end else begin
            for (int i = game_pkg::NUM_PLAT_L2 - 1; i >= 0; i--) begin
                if (in_window(game_pkg::PLATFORMS_L2[i], plat.x, plat.y)) begin
                    plat.hit    = 1'b1;
                    plat.snap_y = game_pkg::PLATFORMS_L2[i].snap_y;
                    plat.goal   = game_pkg::PLATFORMS_L2[i].goal;
                end
            end
        end
    end

endmodule

//--- physics/player_physics.sv
`timescale 1ns/100ps

module player_physics (
    input  logic              clk,
    input  logic              rst,
    input  logic              tick,
    input  game_pkg::move_e   move,
    input  logic              jump,
    player_state_if.physics   st,
    platform_if.physics       plat
);

    game_pkg::grav_t  gravity;
    game_pkg::grav_t  gravity_next;
    game_pkg::grav_t  fall;
    game_pkg::coord_t x_next;
    game_pkg::coord_t y_next;

    // platform lookup runs on the pre-step position
    assign plat.level = st.level;
    assign plat.x     = st.x;
    assign plat.y     = st.y;

    assign fall = gravity >>> game_pkg::GRAV_SHIFT;

    always_comb begin
        if (gravity != game_pkg::GRAV_MAX) begin
            gravity_next = gravity + 20'sd1;
        end else begin
            gravity_next = gravity;
        end

        if (plat.hit) begin
            gravity_next = '0;
            // jump only from a platform, and not past the floor value
            if (jump && (gravity != game_pkg::JUMP_FLOOR)) begin
                gravity_next = gravity - game_pkg::JUMP_STEP;
            end
        end
    end

    always_comb begin
        // low bits of the signed fall add as two's complement
        y_next = st.y + fall[9:0];
        if (plat.hit && (st.y != plat.snap_y)) begin
            y_next = plat.snap_y;
        end
    end

    always_comb begin
        x_next = st.x;
        if ((move == game_pkg::MOVE_RIGHT) && (st.x <= game_pkg::X_RIGHT_MAX)) begin
            x_next = st.x + 10'd1;
        end else if ((move == game_pkg::MOVE_LEFT) && (st.x >= game_pkg::X_LEFT_MIN)) begin
            x_next = st.x - 10'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st.x    <= game_pkg::RESET_X;
            st.y    <= game_pkg::RESET_Y;
            gravity <= '0;
        end else if (tick) begin
            if (st.spawn_req) begin
                st.x <= st.spawn_x;
                st.y <= st.spawn_y;
            end else if (st.active) begin
                st.x <= x_next;
                st.y <= y_next;
            end

            // gravity keeps running through a respawn
            if (st.active) begin
                gravity <= gravity_next;
            end
        end
    end

endmodule

//--- hdl/level_control.sv
`timescale 1ns/100ps

module level_control #(
    parameter logic [15:0] SPAWN_THRESHOLD = 16'h8000
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             tick,
    input  logic [15:0]      rand_word,
    input  logic             goal_hit,
    player_state_if.control  st
);

    logic first_spawn;
    logic fell_off;

    assign first_spawn = !st.active && (rand_word > SPAWN_THRESHOLD);
    assign fell_off    = st.active && (st.y >= game_pkg::BOTTOM_Y);

    assign st.spawn_req = first_spawn || fell_off;

    // spawn point for first appearance, otherwise the level's respawn point
    always_comb begin
        if (!st.active) begin
            st.spawn_x = game_pkg::SPAWN_X;
            st.spawn_y = game_pkg::SPAWN_Y;
        end else if (st.level == game_pkg::LEVEL_2) begin
            st.spawn_x = game_pkg::RESPAWN_L2_X;
            st.spawn_y = game_pkg::RESPAWN_L2_Y;
        end else begin
            st.spawn_x = game_pkg::RESPAWN_L1_X;
            st.spawn_y = game_pkg::RESPAWN_L1_Y;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st.active <= 1'b0;
            st.level  <= game_pkg::LEVEL_1;
        end else if (tick) begin
            if (first_spawn) begin
                st.active <= 1'b1;
            end
            // level 2 has no goal, so the level only moves forward once
            if (st.active && goal_hit && (st.level == game_pkg::LEVEL_1)) begin
                st.level <= game_pkg::LEVEL_2;
            end
        end
    end

endmodule

//--- hdl/player_update.sv
`timescale 1ns/100ps

module player_update #(
    parameter logic [15:0] SPAWN_THRESHOLD = 16'h8000
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  game_pkg::speed_t  speed,
    input  logic [15:0]       rand_word,
    input  logic [2:0]        player_input,
    output game_pkg::coord_t  active_column,
    output game_pkg::coord_t  note_y_position,
    output logic              note_active,
    output game_pkg::level_e  level
);

    logic            tick;
    game_pkg::move_e move;
    logic            jump;
    logic            goal_hit;

    player_state_if state ();
    platform_if     plat ();

    step_input step_input_inst (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .speed        (speed),
        .player_input (player_input),
        .tick         (tick),
        .move         (move),
        .jump         (jump)
    );

    player_physics player_physics_inst (
        .clk  (clk),
        .rst  (rst),
        .tick (tick),
        .move (move),
        .jump (jump),
        .st   (state.physics),
        .plat (plat.physics)
    );

    platform_map platform_map_inst (
        .plat (plat.map)
    );

    // only a landing on the goal platform counts
    assign goal_hit = plat.goal & plat.hit;

    level_control #(
        .SPAWN_THRESHOLD (SPAWN_THRESHOLD)
    ) level_control_inst (
        .clk       (clk),
        .rst       (rst),
        .tick      (tick),
        .rand_word (rand_word),
        .goal_hit  (goal_hit),
        .st        (state.control)
    );

    assign active_column   = state.x;
    assign note_y_position = state.y;
    assign note_active     = state.active;
    assign level           = state.level;

endmodule

//--- tests/player_chk.sv
`timescale 1ns/100ps

module player_chk (
    input logic             clk,
    input logic             rst,
    input logic             tick,
    input game_pkg::coord_t active_column,
    input game_pkg::coord_t note_y_position,
    input logic             note_active,
    input game_pkg::level_e level
);

    // player is absent right after reset
    assert property (@(posedge clk) $fell(rst) |-> (note_active == 1'b0))
        else $error("player active in the first cycle after reset");

    assert property (@(posedge clk) disable iff (rst)
        active_column <= game_pkg::X_LIMIT)
        else $error("column beyond the right limit");

    // level only moves forward
    assert property (@(posedge clk) disable iff (rst)
        (level == game_pkg::LEVEL_2) |=> (level == game_pkg::LEVEL_2))
        else $error("level went back to level 1 without reset");

    // state only changes on a step
    assert property (@(posedge clk) disable iff (rst)
        !$past(tick) |-> $stable({active_column, note_y_position, note_active, level}))
        else $error("outputs changed without a step");

endmodule

bind player_update player_chk player_chk_inst (
    .clk             (clk),
    .rst             (rst),
    .tick            (tick),
    .active_column   (active_column),
    .note_y_position (note_y_position),
    .note_active     (note_active),
    .level           (level)
);

//--- tests/player_tb.sv
`timescale 1ns/100ps

module player_tb;

    localparam logic [15:0] THRESHOLD = 16'h8000;

    typedef struct {
        game_pkg::speed_t speed;
        logic [15:0]      rnd;
        logic [2:0]       pin;
        logic             start;
        int               steps;
        game_pkg::coord_t x;
        game_pkg::coord_t y;
        game_pkg::level_e lvl;
        logic             act;
        logic             use_model;
    } row_t;

    logic             clk;
    logic             rst;
    logic             start;
    game_pkg::speed_t speed;
    logic [15:0]      rand_word;
    logic [2:0]       player_input;
    game_pkg::coord_t active_column;
    game_pkg::coord_t note_y_position;
    logic             note_active;
    game_pkg::level_e level;

    row_t rows[$];
    int   cycle_count;
    int   cycle_limit;

    // reference model state
    game_pkg::coord_t m_x;
    game_pkg::coord_t m_y;
    game_pkg::grav_t  m_grav;
    logic             m_active;
    game_pkg::level_e m_level;

    player_update #(
        .SPAWN_THRESHOLD (THRESHOLD)
    ) player_update_inst (
        .clk             (clk),
        .rst             (rst),
        .start           (start),
        .speed           (speed),
        .rand_word       (rand_word),
        .player_input    (player_input),
        .active_column   (active_column),
        .note_y_position (note_y_position),
        .note_active     (note_active),
        .level           (level)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    initial begin
        cycle_count = 0;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the table did not finish", cycle_count);
            $display("Simulation failed");
            $fatal(1, "run stopped on timeout");
        end
    end

    task automatic add_row(input game_pkg::speed_t sp, input logic [15:0] rnd,
                           input logic [2:0] pin, input logic st, input int steps,
                           input game_pkg::coord_t x, input game_pkg::coord_t y,
                           input game_pkg::level_e lvl, input logic act,
                           input logic use_model);
        row_t r;
        r.speed = sp;
        r.rnd = rnd;
        r.pin = pin;
        r.start = st;
        r.steps = steps;
        r.x = x;
        r.y = y;
        r.lvl = lvl;
        r.act = act;
        r.use_model = use_model;
        rows.push_back(r);
    endtask

    // first platform of the level whose window holds the point
    task automatic lookup_platform(input game_pkg::level_e lvl, input game_pkg::coord_t x,
                                   input game_pkg::coord_t y, output logic hit,
                                   output game_pkg::coord_t snap, output logic goal);
        game_pkg::platform_t p;
        int n;
        hit = 1'b0;
        snap = '0;
        goal = 1'b0;
        n = (lvl == game_pkg::LEVEL_1) ? game_pkg::NUM_PLAT_L1 : game_pkg::NUM_PLAT_L2;
        for (int i = 0; i < n; i++) begin
            if (lvl == game_pkg::LEVEL_1) begin
                p = game_pkg::PLATFORMS_L1[i];
            end else begin
                p = game_pkg::PLATFORMS_L2[i];
            end
            if (!hit && x >= p.x_lo && x <= p.x_hi &&
                y >= p.snap_y - game_pkg::WIN_ABOVE &&
                y <= p.snap_y + game_pkg::WIN_BELOW) begin
                hit = 1'b1;
                snap = p.snap_y;
                goal = p.goal;
            end
        end
    endtask

    task automatic model_step(input logic [15:0] rnd, input logic [2:0] pin);
        logic             hit;
        logic             goal;
        logic             first;
        logic             fell;
        logic             rp;
        logic             lp;
        logic             jp;
        game_pkg::coord_t snap;
        game_pkg::coord_t x_next;
        game_pkg::coord_t y_next;
        game_pkg::coord_t sp_x;
        game_pkg::coord_t sp_y;
        game_pkg::grav_t  g_next;
        game_pkg::grav_t  fall;
        lookup_platform(m_level, m_x, m_y, hit, snap, goal);
        rp = !pin[0];
        lp = !pin[2];
        jp = !pin[1];
        first = !m_active && (rnd > THRESHOLD);
        fell = m_active && (m_y >= game_pkg::BOTTOM_Y);

        g_next = (m_grav == game_pkg::GRAV_MAX) ? m_grav : m_grav + 20'sd1;
        if (hit) begin
            if (jp && m_grav != game_pkg::JUMP_FLOOR) begin
                g_next = m_grav - game_pkg::JUMP_STEP;
            end else begin
                g_next = '0;
            end
        end

        fall = m_grav >>> game_pkg::GRAV_SHIFT;
        if (hit && m_y != snap) begin
            y_next = snap;
        end else begin
            y_next = m_y + fall[9:0];
        end

        x_next = m_x;
        if (rp && !lp && m_x <= game_pkg::X_RIGHT_MAX) begin
            x_next = m_x + 10'd1;
        end else if (lp && !rp && m_x >= game_pkg::X_LEFT_MIN) begin
            x_next = m_x - 10'd1;
        end

        if (!m_active) begin
            sp_x = game_pkg::SPAWN_X;
            sp_y = game_pkg::SPAWN_Y;
        end else if (m_level == game_pkg::LEVEL_2) begin
            sp_x = game_pkg::RESPAWN_L2_X;
            sp_y = game_pkg::RESPAWN_L2_Y;
        end else begin
            sp_x = game_pkg::RESPAWN_L1_X;
            sp_y = game_pkg::RESPAWN_L1_Y;
        end

        if (first || fell) begin
            m_x = sp_x;
            m_y = sp_y;
        end else if (m_active) begin
            m_x = x_next;
            m_y = y_next;
        end
        if (m_active) begin
            m_grav = g_next;
            if (hit && goal && m_level == game_pkg::LEVEL_1) begin
                m_level = game_pkg::LEVEL_2;
            end
        end
        if (first) begin
            m_active = 1'b1;
        end
    endtask

    task automatic check_coord(input string name, input game_pkg::coord_t got,
                               input game_pkg::coord_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "coordinate check");
        end
    endtask

    task automatic check_level(input string name, input game_pkg::level_e got,
                               input game_pkg::level_e exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %s expected %s", $time, name,
                     got.name(), exp.name());
            $display("Simulation failed");
            $fatal(1, "level check");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "flag check");
        end
    endtask

    task automatic check_outputs();
        check_coord("active_column", active_column, m_x);
        check_coord("note_y_position", note_y_position, m_y);
        check_flag("note_active", note_active, m_active);
        check_level("level", level, m_level);
    endtask

    initial begin
        int cycles;
        logic [15:0] filler;
        rst = 1'b1;
        start = 1'b0;
        speed = '0;
        rand_word = '0;
        player_input = 3'b111;
        void'($urandom(22484));

        // spawn gating, fall, walking and speed change
        add_row(20'd3, 16'h1000, 3'b111, 1'b1, 3, 10'd2, 10'd100, game_pkg::LEVEL_1, 0, 0);
        add_row(20'd3, 16'h8000, 3'b111, 1'b1, 2, 10'd2, 10'd100, game_pkg::LEVEL_1, 0, 0);
        add_row(20'd3, 16'hF000, 3'b111, 1'b1, 1, 10'd5, 10'd100, game_pkg::LEVEL_1, 1, 0);
        add_row(20'd1, 16'h0000, 3'b111, 1'b1, 120, 10'd5, 10'd373, game_pkg::LEVEL_1, 1, 0);
        add_row(20'd1, 16'h0000, 3'b110, 1'b1, 10, 10'd15, 10'd373, game_pkg::LEVEL_1, 1, 0);
        add_row(20'd1, 16'h0000, 3'b011, 1'b1, 5, 10'd10, 10'd373, game_pkg::LEVEL_1, 1, 0);
        add_row(20'd1, 16'h0000, 3'b010, 1'b1, 4, 10'd10, 10'd373, game_pkg::LEVEL_1, 1, 0);
        add_row(20'd1, 16'h0000, 3'b110, 1'b0, 5, 10'd10, 10'd373, game_pkg::LEVEL_1, 1, 0);
        add_row(20'd5, 16'h0000, 3'b110, 1'b1, 3, 10'd13, 10'd373, game_pkg::LEVEL_1, 1, 0);
        // jump from the floor, then settle back
        add_row(20'd1, 16'h0000, 3'b101, 1'b1, 1, 10'd0, 10'd0, game_pkg::LEVEL_1, 1, 1);
        add_row(20'd1, 16'h0000, 3'b111, 1'b1, 1, 10'd13, 10'd371, game_pkg::LEVEL_1, 1, 0);
        add_row(20'd1, 16'h0000, 3'b111, 1'b1, 3, 10'd0, 10'd0, game_pkg::LEVEL_1, 1, 1);
        // walk off the edge and fall past the bottom
        add_row(20'd1, 16'h0000, 3'b110, 1'b1, 138, 10'd0, 10'd0, game_pkg::LEVEL_1, 1, 1);
        add_row(20'd1, 16'h0000, 3'b111, 1'b1, 60, 10'd0, 10'd0, game_pkg::LEVEL_1, 1, 1);
        for (int i = 0; i < 2; i++) begin
            filler = 16'($urandom());
            add_row(20'd2, filler, 3'b111, 1'b1, 4, 10'd0, 10'd0, game_pkg::LEVEL_1, 1, 1);
        end
        // land after the respawn while pressing left into the bound
        add_row(20'd1, 16'h0000, 3'b011, 1'b1, 90, 10'd2, 10'd373, game_pkg::LEVEL_1, 1, 0);

        cycle_limit = 100;
        foreach (rows[i]) begin
            cycle_limit = cycle_limit + rows[i].steps * (int'(rows[i].speed) + 1);
        end

        m_x = game_pkg::RESET_X;
        m_y = game_pkg::RESET_Y;
        m_grav = '0;
        m_active = 1'b0;
        m_level = game_pkg::LEVEL_1;

        repeat (8) @(posedge clk);
        #2 rst = 1'b0;

        foreach (rows[i]) begin
            speed = rows[i].speed;
            rand_word = rows[i].rnd;
            player_input = rows[i].pin;
            start = rows[i].start;
            cycles = rows[i].steps * (int'(rows[i].speed) + 1);
            for (int c = 0; c < cycles; c++) begin
                @(posedge clk);
                // with start low nothing may move
                if (!rows[i].start) begin
                    #1 check_outputs();
                end
            end
            #1;
            if (rows[i].start) begin
                repeat (rows[i].steps) model_step(rows[i].rnd, rows[i].pin);
            end
            if (!rows[i].use_model) begin
                if (rows[i].x !== m_x || rows[i].y !== m_y ||
                    rows[i].lvl !== m_level || rows[i].act !== m_active) begin
                    $display("reference model does not agree with table row %0d", i);
                    $display("Simulation failed");
                    $fatal(1, "table entry check");
                end
            end
            check_outputs();
            #1;
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

//--- tb.f
common/game_pkg.sv
common/player_state_if.sv
common/platform_if.sv
hdl/step_input.sv
physics/platform_map.sv
physics/player_physics.sv
hdl/level_control.sv
hdl/player_update.sv
tests/player_chk.sv
tests/player_tb.sv

//--- Makefile
VERILATOR  = verilator
TOP        = player_tb
FILELIST   = tb.f
BUILD_DIR  = obj_dir
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
